/* Makefile */
TB_TOP := cache_mem_subsystem_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing \
		-f cache_mem_subsystem.f \
		--top-module $(TB_TOP)

sim:
	verilator --binary --timing -j 0 \
		-f cache_mem_subsystem.f \
		--top-module $(TB_TOP) \
		-Mdir obj_dir \
		-o $(TB_TOP)_sim
	./obj_dir/$(TB_TOP)_sim | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

/* cache_mem_subsystem.f */
source/rv32i_mem_pkg.sv
source/cache_arbiter.sv
source/line_memory.sv
source/cache_mem_subsystem.sv
verif/cache_mem_subsystem_tb.sv

/* source/cache_arbiter.sv */
`timescale 1ns/1ps

module cache_arbiter
    import rv32i_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  icache_req_t icache_req,
    input  dcache_req_t dcache_req,
    output mem_rsp_t    icache_rsp,
    output mem_rsp_t    dcache_rsp,

    output dcache_req_t mem_req,
    input  mem_rsp_t    mem_rsp
);

    arb_state_t state;
    arb_state_t next_state;

    logic icache_pending;
    logic dcache_pending;
    logic icache_done;
    logic dcache_done;

    // a cache is pending for as long as it holds a strobe high.
    assign icache_pending = icache_req.read;
    assign dcache_pending = dcache_req.read | dcache_req.write;

    // the memory response only completes a transfer for the side that owns the port.
    assign icache_done = (state == arb_icache) && mem_rsp.resp;
    assign dcache_done = (state == arb_dcache) && mem_rsp.resp;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arb_idle;
        end else begin
            state <= next_state;
        end
    end

    // the instruction side wins from idle, and after each response the other
    // side is served if it is waiting, so the two alternate under contention.
    always_comb begin
        next_state = state;
        case (state)
            arb_idle: begin
                if (icache_pending) begin
                    next_state = arb_icache;
                end else if (dcache_pending) begin
                    next_state = arb_dcache;
                end
            end
            arb_icache: begin
                if (icache_done) begin
                    if (dcache_pending) begin
                        next_state = arb_dcache;
                    end else begin
                        next_state = arb_idle;
                    end
                end
            end
            arb_dcache: begin
                if (dcache_done) begin
                    if (icache_pending) begin
                        next_state = arb_icache;
                    end else begin
                        next_state = arb_idle;
                    end
                end
            end
            default: begin
                next_state = arb_idle;
            end
        endcase
    end

    // request path toward memory.
    // the instruction request has no write fields, so those stay zero.
    always_comb begin
        mem_req = '0;
        case (state)
            arb_icache: begin
                mem_req.addr  = icache_req.addr;
                mem_req.read  = icache_req.read;
                mem_req.write = 1'b0;
                mem_req.wdata = '0;
            end
            arb_dcache: begin
                mem_req.addr  = dcache_req.addr;
                mem_req.read  = dcache_req.read;
                mem_req.write = dcache_req.write;
                mem_req.wdata = dcache_req.wdata;
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

    // response path back to the caches.
    // the side that is not granted sees zero data and no resp pulse.
    always_comb begin
        icache_rsp = '0;
        dcache_rsp = '0;
        case (state)
            arb_icache: begin
                icache_rsp = mem_rsp;
            end
            arb_dcache: begin
                dcache_rsp = mem_rsp;
            end
            default: begin
                icache_rsp = '0;
                dcache_rsp = '0;
            end
        endcase
    end

endmodule

/* source/cache_mem_subsystem.sv */
`timescale 1ns/1ps

module cache_mem_subsystem
    import rv32i_mem_pkg::*;
#(
    // number of lines in the backing store, a power of two.
    parameter int line_count  = 16,
    // cycles a granted request is held before memory answers, at least one.
    parameter int mem_latency = 3
) (
    input  logic        clk,
    input  logic        rst,

    input  icache_req_t icache_req,
    input  dcache_req_t dcache_req,
    output mem_rsp_t    icache_rsp,
    output mem_rsp_t    dcache_rsp
);

    // shared memory port between the arbiter and the backing store.
    dcache_req_t mem_req;
    mem_rsp_t    mem_rsp;

    // the arbiter decides which cache owns the memory port.
    cache_arbiter cache_arbiter_inst (
        .clk        (clk),
        .rst        (rst),
        .icache_req (icache_req),
        .dcache_req (dcache_req),
        .icache_rsp (icache_rsp),
        .dcache_rsp (dcache_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    // only the backing store depends on the size and latency settings.
    line_memory #(
        .line_count  (line_count),
        .mem_latency (mem_latency)
    ) line_memory_inst (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

/* source/line_memory.sv */
`timescale 1ns/1ps

module line_memory
    import rv32i_mem_pkg::*;
#(
    parameter int line_count  = 16,
    parameter int mem_latency = 3
) (
    input  logic        clk,
    input  logic        rst,

    input  dcache_req_t mem_req,
    output mem_rsp_t    mem_rsp
);

    // line_count is a power of two, so the index is a plain bit field.
    localparam int index_bits = $clog2(line_count);

    // the counter must be able to hold mem_latency itself.
    localparam int count_bits = $clog2(mem_latency + 1);

    typedef logic [index_bits-1:0] line_index_t;
    typedef logic [count_bits-1:0] latency_count_t;

    localparam latency_count_t count_done = latency_count_t'(mem_latency);

    rv32i_cacheline lines [line_count];

    line_index_t    line_index;
    latency_count_t count;
    logic           strobe;
    logic           respond;
    logic           write_fire;

    // address bits above the index are ignored, so such addresses alias.
    assign line_index = mem_req.addr[line_offset_bits +: index_bits];

    assign strobe = mem_req.read | mem_req.write;

    // count holds the number of earlier cycles in this run with a strobe high.
    // once it reaches mem_latency the request has been held long enough.
    assign respond = strobe && (count == count_done);

    // a write lands on the edge that ends its response cycle.
    assign write_fire = respond && mem_req.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (!strobe || respond) begin
            // a dropped strobe or a finished request starts the next run from zero.
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < line_count; i++) begin
                lines[i] <= '0;
            end
        end else if (write_fire) begin
            lines[line_index] <= mem_req.wdata;
        end
    end

    // read data is shown only in the response cycle.
    // for a write it returns the old line, which the caches ignore.
    always_comb begin
        mem_rsp.resp = respond;
        if (respond) begin
            mem_rsp.rdata = lines[line_index];
        end else begin
            mem_rsp.rdata = '0;
        end
    end

endmodule

/* source/rv32i_mem_pkg.sv */
package rv32i_mem_pkg;

    // widths shared by the caches, the arbiter and the backing store.
    localparam int word_bits = 32;
    localparam int line_bits = 256;

    // a line holds 32 bytes, so the low five address bits select a byte in it.
    localparam int line_offset_bits = 5;

    // byte address or data word.
    typedef logic [word_bits-1:0] rv32i_word;

    // one whole cache line, the unit of every memory transfer.
    typedef logic [line_bits-1:0] rv32i_cacheline;

    // the instruction cache only ever reads.
    typedef struct packed {
        rv32i_word addr;
        logic      read;
    } icache_req_t;

    // the data cache reads and writes back whole lines.
    // read and write are never raised together.
    typedef struct packed {
        rv32i_word      addr;
        rv32i_cacheline wdata;
        logic           read;
        logic           write;
    } dcache_req_t;

    // response from memory, and from the arbiter to either cache.
    // rdata is only meaningful in the cycle where resp is high.
    typedef struct packed {
        rv32i_cacheline rdata;
        logic           resp;
    } mem_rsp_t;

    // arbiter ownership of the shared memory port.
    typedef enum logic [1:0] {
        arb_idle,
        arb_icache,
        arb_dcache
    } arb_state_t;

endpackage

/* verif/cache_mem_subsystem_tb.sv */
`timescale 1ns/1ps

module cache_mem_subsystem_tb
    import rv32i_mem_pkg::*;
();

    localparam int line_count     = 16;
    localparam int mem_latency    = 3;
    localparam int timeout_cycles = 40;
    localparam int random_rounds  = 300;

    logic        clk;
    logic        rst;
    icache_req_t icache_req;
    dcache_req_t dcache_req;
    mem_rsp_t    icache_rsp;
    mem_rsp_t    dcache_rsp;

    logic [31:0]    lfsr_state;
    rv32i_cacheline shadow [line_count];
    logic           monitor_on;
    int             transactions;

    cache_mem_subsystem #(
        .line_count  (line_count),
        .mem_latency (mem_latency)
    ) cache_mem_subsystem_inst (
        .clk        (clk),
        .rst        (rst),
        .icache_req (icache_req),
        .dcache_req (dcache_req),
        .icache_rsp (icache_rsp),
        .dcache_rsp (dcache_rsp)
    );

    always #2 clk = ~clk;

    // taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic rand_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic rv32i_word rand_word();
        rv32i_word w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], rand_bit()};
        end
        return w;
    endfunction

    function automatic rv32i_cacheline rand_line();
        rv32i_cacheline l;
        l = '0;
        for (int i = 0; i < 256; i++) begin
            l = {l[254:0], rand_bit()};
        end
        return l;
    endfunction

    // the line number wraps at line_count, so higher address bits alias.
    function automatic int line_index(input rv32i_word addr);
        return int'(addr[31:line_offset_bits]) % line_count;
    endfunction

    function automatic rv32i_cacheline expected_line(input rv32i_word addr);
        return shadow[line_index(addr)];
    endfunction

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_line(input string name, input rv32i_cacheline expected,
                              input rv32i_cacheline actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    // cycles counts from the cycle in which the request was raised.
    task automatic wait_response(input string what, input logic from_icache,
                                 output int cycles, output rv32i_cacheline rdata);
        mem_rsp_t rsp;
        cycles = 0;
        @(negedge clk);
        rsp = from_icache ? icache_rsp : dcache_rsp;
        while (!rsp.resp) begin
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("timeout: %s got no response within %0d cycles",
                         what, timeout_cycles);
                abort_run();
            end
            @(negedge clk);
            rsp = from_icache ? icache_rsp : dcache_rsp;
        end
        rdata = rsp.rdata;
    endtask

    task automatic icache_read(input string name, input rv32i_word addr,
                               output rv32i_cacheline data, output int cycles);
        rv32i_cacheline expected;
        @(posedge clk);
        icache_req.addr <= addr;
        icache_req.read <= 1'b1;
        wait_response(name, 1'b1, cycles, data);
        expected = expected_line(addr);
        check_line(name, expected, data);
        transactions++;
        @(posedge clk);
        icache_req <= '0;
    endtask

    task automatic dcache_read(input string name, input rv32i_word addr,
                               output rv32i_cacheline data, output int cycles);
        rv32i_cacheline expected;
        @(posedge clk);
        dcache_req.addr  <= addr;
        dcache_req.wdata <= '0;
        dcache_req.read  <= 1'b1;
        dcache_req.write <= 1'b0;
        wait_response(name, 1'b0, cycles, data);
        expected = expected_line(addr);
        check_line(name, expected, data);
        transactions++;
        @(posedge clk);
        dcache_req <= '0;
    endtask

    // the write lands at the edge that ends the response cycle.
    task automatic dcache_write(input string name, input rv32i_word addr,
                                input rv32i_cacheline wdata, output int cycles);
        rv32i_cacheline ignored;
        @(posedge clk);
        dcache_req.addr  <= addr;
        dcache_req.wdata <= wdata;
        dcache_req.read  <= 1'b0;
        dcache_req.write <= 1'b1;
        wait_response(name, 1'b0, cycles, ignored);
        shadow[line_index(addr)] = wdata;
        transactions++;
        @(posedge clk);
        dcache_req <= '0;
    endtask

    // a cache that is not waiting must never see a pulse or stray data.
    always @(negedge clk) begin
        if (monitor_on) begin
            if (!icache_req.read) begin
                check_flag("icache resp without request", 1'b0, icache_rsp.resp);
            end
            if (!(dcache_req.read || dcache_req.write)) begin
                check_flag("dcache resp without request", 1'b0, dcache_rsp.resp);
            end
            if (!icache_rsp.resp) begin
                check_line("icache rdata outside response", '0, icache_rsp.rdata);
            end
            if (!dcache_rsp.resp) begin
                check_line("dcache rdata outside response", '0, dcache_rsp.rdata);
            end
        end
    end

    initial begin
        rv32i_word      addr;
        rv32i_word      alias_addr;
        rv32i_cacheline wdata;
        rv32i_cacheline data;
        rv32i_cacheline idata;
        rv32i_cacheline ddata;
        int             cycles;
        int             icycles;
        int             dcycles;
        logic           pick_hi;
        logic           pick_lo;
        logic           pick_op;

        clk          = 1'b0;
        rst          <= 1'b1;
        icache_req   <= '0;
        dcache_req   <= '0;
        monitor_on   <= 1'b0;
        transactions = 0;
        lfsr_state   = 32'h78632338;
        for (int i = 0; i < line_count; i++) begin
            shadow[i] = '0;
        end

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        monitor_on <= 1'b1;

        // nothing is requested, so both sides stay quiet and memory reads back zero.
        repeat (8) begin
            @(negedge clk);
            check_flag("idle icache resp", 1'b0, icache_rsp.resp);
            check_flag("idle dcache resp", 1'b0, dcache_rsp.resp);
        end
        for (int i = 0; i < 4; i++) begin
            addr = rand_word();
            dcache_read("read after reset", addr, data, cycles);
        end

        // index bits [8:5] are equal for both addresses.
        addr       = 32'h0000_0040;
        alias_addr = 32'habc0_0040;
        wdata      = rand_line();
        dcache_write("write line", addr, wdata, cycles);
        dcache_read("read back", addr, data, cycles);
        check_line("read back", wdata, data);
        dcache_read("alias read", alias_addr, data, cycles);
        check_line("alias read", wdata, data);
        wdata = rand_line();
        dcache_write("alias write", alias_addr, wdata, cycles);
        dcache_read("read after alias write", addr, data, cycles);
        check_line("read after alias write", wdata, data);

        addr  = 32'h0000_01a0;
        wdata = rand_line();
        dcache_write("write for icache", addr, wdata, cycles);
        icache_read("shared icache read", addr, data, cycles);
        check_line("shared icache read", wdata, data);

        icache_read("lone icache read", 32'h0000_0040, data, cycles);
        check_cycles("lone icache latency", mem_latency + 1, cycles);
        dcache_read("lone dcache read", 32'h0000_01a0, data, cycles);
        check_cycles("lone dcache latency", mem_latency + 1, cycles);

        addr  = 32'h0000_0120;
        wdata = rand_line();
        dcache_write("write for contention", addr, wdata, cycles);
        fork
            icache_read("contended icache read", addr, idata, icycles);
            dcache_read("contended dcache read", 32'h0000_0040, ddata, dcycles);
        join
        check_cycles("contended icache latency", mem_latency + 1, icycles);
        check_flag("icache served first", 1'b1, icycles < dcycles);
        check_line("contended icache data", wdata, idata);

        for (int n = 0; n < random_rounds; n++) begin
            pick_hi = rand_bit();
            pick_lo = rand_bit();
            addr    = rand_word();
            case ({pick_hi, pick_lo})
                2'b00: begin
                    icache_read("random icache read", addr, data, cycles);
                end
                2'b01: begin
                    dcache_read("random dcache read", addr, data, cycles);
                end
                2'b10: begin
                    wdata = rand_line();
                    dcache_write("random dcache write", addr, wdata, cycles);
                end
                default: begin
                    pick_op    = rand_bit();
                    wdata      = rand_line();
                    alias_addr = rand_word();
                    fork
                        icache_read("random overlapped icache read", addr, idata, icycles);
                        begin
                            if (pick_op) begin
                                dcache_write("random overlapped dcache write",
                                             alias_addr, wdata, dcycles);
                            end else begin
                                dcache_read("random overlapped dcache read",
                                            alias_addr, ddata, dcycles);
                            end
                        end
                    join
                end
            endcase
        end

        $display("%0d transactions completed", transactions);
        $display("*** PASSED ***");
        $finish;
    end

endmodule
